// File: design/radio_ctrl_pkg.sv
/*
 * Radio control plane package: settings bus types, address map,
 * readback indices and the packed control payloads.
 */
`default_nettype none

package radio_ctrl_pkg;

   ////////////////////////////////////////
   // Bus and time types
   typedef logic [7:0]  set_addr_t;    // Settings address
   typedef logic [31:0] set_data_t;    // Settings / readback word
   typedef logic [63:0] vita_time_t;   // {seconds, ticks}
   typedef logic [3:0]  rb_index_t;    // Readback word select
   typedef logic [7:0]  led_t;

   ////////////////////////////////////////
   // Control payloads, MSB first as on the pins
   typedef struct packed {
      logic       clock_ready;
      logic [1:0] clk_en;
      logic [1:0] clk_sel;
   } clock_ctrl_t;

   typedef struct packed {
      logic enable;
      logic prbsen;
      logic loopen;
      logic rx_en;
   } serdes_ctrl_t;

   typedef struct packed {
      logic oe_a;
      logic on_a;
      logic oe_b;
      logic on_b;
   } adc_ctrl_t;

   ////////////////////////////////////////
   // Settings address map
   localparam set_addr_t SR_MISC   = 8'd0;
   localparam set_addr_t SR_TIME64 = 8'd192;

   localparam set_addr_t SR_CLOCK_OFS   = 8'd0;
   localparam set_addr_t SR_SERDES_OFS  = 8'd1;
   localparam set_addr_t SR_ADC_OFS     = 8'd2;
   localparam set_addr_t SR_LED_SW_OFS  = 8'd3;
   localparam set_addr_t SR_PHY_OFS     = 8'd4;
   localparam set_addr_t SR_LED_SRC_OFS = 8'd8;

   localparam set_addr_t TIME_SECS_OFS  = 8'd0;
   localparam set_addr_t TIME_TICKS_OFS = 8'd1;
   localparam set_addr_t TIME_ARM_OFS   = 8'd2;   // Bit 0: 1 now, 0 at next PPS

   localparam led_t      LED_SRC_AT_RESET      = 8'b0000_0011;  // HW drives clk and PPS LEDs
   localparam set_data_t COMPAT_NUM            = 32'd4;
   localparam set_data_t DEFAULT_TICKS_PER_SEC = 32'd100_000_000;

   ////////////////////////////////////////
   // Readback word indices
   localparam rb_index_t RB_CTRL    = 4'd8;
   localparam rb_index_t RB_MODE    = 4'd9;
   localparam rb_index_t RB_TIME_HI = 4'd10;
   localparam rb_index_t RB_TIME_LO = 4'd11;
   localparam rb_index_t RB_COMPAT  = 4'd12;
   localparam rb_index_t RB_PPS_HI  = 4'd14;
   localparam rb_index_t RB_PPS_LO  = 4'd15;

endpackage

`default_nettype wire

// File: design/setting_reg.sv
/*
 * Settings register: latches the low bits of the bus word when its
 * address is strobed, with a one-cycle change pulse.
 */
`default_nettype none

module setting_reg
   import radio_ctrl_pkg::*;
#(
   parameter type       payload_t = set_data_t,
   parameter set_addr_t MY_ADDR   = 8'd0,
   parameter payload_t  AT_RESET  = '0
) (
   input  wire       dsp_clk,
   input  wire       por_rst,
   input  wire       set_stb_i,
   input  set_addr_t set_addr_i,
   input  set_data_t set_data_i,
   output payload_t  value_o,
   output logic      changed_o
);

   localparam int PAYLOAD_W = $bits(payload_t);

   logic hit;

   assign hit = set_stb_i && (set_addr_i == MY_ADDR);

   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         value_o   <= AT_RESET;
         changed_o <= 1'b0;
      end else begin
         changed_o <= hit;
         if (hit)
            value_o <= payload_t'(set_data_i[PAYLOAD_W-1:0]);   // Upper bits ignored
      end
   end

endmodule

`default_nettype wire

// File: design/settings_host_port.sv
/*
 * Host port: turns a four-phase req/ack transfer into one settings
 * strobe, or into a readback read whose word is held while ack is high.
 */
`default_nettype none

module settings_host_port
   import radio_ctrl_pkg::*;
(
   input  wire        dsp_clk,
   input  wire        por_rst,
   input  wire        host_req_i,
   input  wire        host_we_i,
   input  set_addr_t  host_addr_i,
   input  set_data_t  host_wdata_i,
   input  set_data_t  rb_data_i,
   output logic       host_ack_o,
   output set_data_t  host_rdata_o,
   output logic       set_stb_o,
   output set_addr_t  set_addr_o,
   output set_data_t  set_data_o,
   output rb_index_t  rb_index_o
);

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_WRITE,       // Strobe cycle on the settings bus
      ST_READ_WAIT,   // Readback mux settling
      ST_ACK_HIGH     // Waiting for req to drop
   } port_state_t;

   port_state_t state;
   logic        rd_hold;   // Extra cycle for the registered readback

   ////////////////////////////////////////
   // Control FSM
   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         state      <= ST_IDLE;
         host_ack_o <= 1'b0;
         set_stb_o  <= 1'b0;
         rd_hold    <= 1'b0;
      end else begin
         set_stb_o <= 1'b0;
         case (state)
            ST_IDLE: begin
               if (host_req_i && !host_ack_o) begin
                  if (host_we_i) begin
                     set_stb_o <= 1'b1;
                     state     <= ST_WRITE;
                  end else begin
                     rd_hold <= 1'b1;
                     state   <= ST_READ_WAIT;
                  end
               end
            end
            ST_WRITE: begin
               host_ack_o <= 1'b1;   // Register already updated on this edge
               state      <= ST_ACK_HIGH;
            end
            ST_READ_WAIT: begin
               if (rd_hold) begin
                  rd_hold <= 1'b0;
               end else begin
                  host_ack_o <= 1'b1;
                  state      <= ST_ACK_HIGH;
               end
            end
            ST_ACK_HIGH: begin
               if (!host_req_i) begin
                  host_ack_o <= 1'b0;
                  state      <= ST_IDLE;
               end
            end
            default: state <= ST_IDLE;
         endcase
      end
   end

   ////////////////////////////////////////
   // Request capture and read data hold
   always_ff @(posedge dsp_clk) begin
      if (state == ST_IDLE && host_req_i && !host_ack_o) begin
         set_addr_o <= host_addr_i;
         set_data_o <= host_wdata_i;
         rb_index_o <= rb_index_t'(host_addr_i[3:0]);
      end
      if (state == ST_READ_WAIT && !rd_hold)
         host_rdata_o <= rb_data_i;   // Stable for the whole ack phase
   end

endmodule

`default_nettype wire

// File: design/vita_timer.sv
/*
 * VITA time counter, seconds and ticks, with PPS synchronizer,
 * immediate or PPS-armed load, and the PPS time latch.
 */
`default_nettype none

module vita_timer
   import radio_ctrl_pkg::*;
#(
   parameter set_data_t TICKS_PER_SEC = DEFAULT_TICKS_PER_SEC
) (
   input  wire        dsp_clk,
   input  wire        por_rst,
   input  wire        set_stb_i,
   input  set_addr_t  set_addr_i,
   input  set_data_t  set_data_i,
   input  wire        pps_in_i,
   output vita_time_t vita_time_o,
   output vita_time_t vita_time_pps_o,
   output logic       pps_int_o,
   output logic       pps_toggle_o
);

   localparam set_addr_t SECS_ADDR  = SR_TIME64 + TIME_SECS_OFS;
   localparam set_addr_t TICKS_ADDR = SR_TIME64 + TIME_TICKS_OFS;
   localparam set_addr_t ARM_ADDR   = SR_TIME64 + TIME_ARM_OFS;
   localparam set_data_t LAST_TICK  = TICKS_PER_SEC - 32'd1;

   set_data_t  prog_secs, prog_ticks;   // Values waiting to be loaded
   logic       armed;
   logic [2:0] pps_sync;                // Two sync flops plus edge history
   logic       pps_edge;
   logic       load_now, load_pps;
   vita_time_t time_next;

   assign pps_edge = pps_sync[1] & ~pps_sync[2];
   assign load_now = set_stb_i && (set_addr_i == ARM_ADDR) && set_data_i[0];
   assign load_pps = pps_edge && armed;

   ////////////////////////////////////////
   // Programmed time, not cleared by reset
   always_ff @(posedge dsp_clk) begin
      if (set_stb_i && set_addr_i == SECS_ADDR)
         prog_secs <= set_data_i;
      if (set_stb_i && set_addr_i == TICKS_ADDR)
         prog_ticks <= set_data_i;
   end

   // Next time value, load or count
   always_comb begin
      if (load_now || load_pps)
         time_next = {prog_secs, prog_ticks};
      else if (vita_time_o[31:0] == LAST_TICK)
         time_next = {vita_time_o[63:32] + 32'd1, 32'd0};   // Second rollover
      else
         time_next = {vita_time_o[63:32], vita_time_o[31:0] + 32'd1};
   end

   ////////////////////////////////////////
   // Counter, arm flag and PPS tracking
   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         pps_sync        <= 3'b000;
         armed           <= 1'b0;
         vita_time_o     <= '0;
         vita_time_pps_o <= '0;
         pps_int_o       <= 1'b0;
         pps_toggle_o    <= 1'b0;
      end else begin
         pps_sync    <= {pps_sync[1:0], pps_in_i};
         vita_time_o <= time_next;
         pps_int_o   <= pps_edge;

         if (set_stb_i && set_addr_i == ARM_ADDR)
            armed <= ~set_data_i[0];   // 0 arms for the next PPS
         else if (load_pps)
            armed <= 1'b0;

         if (pps_edge) begin
            vita_time_pps_o <= time_next;   // Time as taken on this edge
            pps_toggle_o    <= ~pps_toggle_o;
         end
      end
   end

endmodule

`default_nettype wire

// File: design/control_outputs.sv
/*
 * Control setting bank: clock generator, SERDES, ADC and PHY reset
 * registers plus the per-bit hardware/software LED mux.
 */
`default_nettype none

module control_outputs
   import radio_ctrl_pkg::*;
(
   input  wire          dsp_clk,
   input  wire          por_rst,
   input  wire          set_stb_i,
   input  set_addr_t    set_addr_i,
   input  set_data_t    set_data_i,
   input  wire          clk_status_i,
   input  wire          pps_toggle_i,
   output clock_ctrl_t  clock_ctrl_o,
   output serdes_ctrl_t serdes_ctrl_o,
   output adc_ctrl_t    adc_ctrl_o,
   output logic         phy_reset_n_o,
   output led_t         leds_o
);

   logic phy_reset;
   led_t led_sw, led_src, led_hw;

   ////////////////////////////////////////
   // Pin control registers
   setting_reg #(.payload_t(clock_ctrl_t), .MY_ADDR(SR_MISC + SR_CLOCK_OFS)) i_sr_clock (
      .dsp_clk, .por_rst, .set_stb_i, .set_addr_i, .set_data_i,
      .value_o(clock_ctrl_o), .changed_o()
   );

   setting_reg #(.payload_t(serdes_ctrl_t), .MY_ADDR(SR_MISC + SR_SERDES_OFS)) i_sr_serdes (
      .dsp_clk, .por_rst, .set_stb_i, .set_addr_i, .set_data_i,
      .value_o(serdes_ctrl_o), .changed_o()
   );

   setting_reg #(.payload_t(adc_ctrl_t), .MY_ADDR(SR_MISC + SR_ADC_OFS)) i_sr_adc (
      .dsp_clk, .por_rst, .set_stb_i, .set_addr_i, .set_data_i,
      .value_o(adc_ctrl_o), .changed_o()
   );

   setting_reg #(.payload_t(logic), .MY_ADDR(SR_MISC + SR_PHY_OFS)) i_sr_phy (
      .dsp_clk, .por_rst, .set_stb_i, .set_addr_i, .set_data_i,
      .value_o(phy_reset), .changed_o()
   );

   assign phy_reset_n_o = ~phy_reset;   // PHY reset pin is active low

   ////////////////////////////////////////
   // LEDs, led_src bit 1 selects hardware
   setting_reg #(.payload_t(led_t), .MY_ADDR(SR_MISC + SR_LED_SW_OFS)) i_sr_led_sw (
      .dsp_clk, .por_rst, .set_stb_i, .set_addr_i, .set_data_i,
      .value_o(led_sw), .changed_o()
   );

   setting_reg #(
      .payload_t(led_t),
      .MY_ADDR  (SR_MISC + SR_LED_SRC_OFS),
      .AT_RESET (LED_SRC_AT_RESET)
   ) i_sr_led_src (
      .dsp_clk, .por_rst, .set_stb_i, .set_addr_i, .set_data_i,
      .value_o(led_src), .changed_o()
   );

   assign led_hw = {6'b0, pps_toggle_i, clk_status_i};

   always_ff @(posedge dsp_clk) begin
      if (por_rst)
         leds_o <= '0;
      else
         leds_o <= (led_src & led_hw) | (~led_src & led_sw);
   end

endmodule

`default_nettype wire

// File: design/status_readback.sv
/*
 * Status readback: registered 16-word mux of control state, mode pins,
 * compat number, current time and PPS time.
 */
`default_nettype none

module status_readback
   import radio_ctrl_pkg::*;
(
   input  wire          dsp_clk,
   input  wire          por_rst,
   input  rb_index_t    rb_index_i,
   input  clock_ctrl_t  clock_ctrl_i,
   input  serdes_ctrl_t serdes_ctrl_i,
   input  adc_ctrl_t    adc_ctrl_i,
   input  wire          sim_mode_i,
   input  wire [3:0]    clock_divider_i,
   input  vita_time_t   vita_time_i,
   input  vita_time_t   vita_time_pps_i,
   output set_data_t    rb_data_o
);

   set_data_t ctrl_word, mode_word;

   // adc 12..9, serdes 8..5, clock 4..0
   assign ctrl_word = {19'b0, adc_ctrl_i, serdes_ctrl_i, clock_ctrl_i};
   assign mode_word = {sim_mode_i, 27'b0, clock_divider_i};

   ////////////////////////////////////////
   // Word select, one cycle of latency
   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         rb_data_o <= '0;
      end else begin
         case (rb_index_i)
            RB_CTRL:    rb_data_o <= ctrl_word;
            RB_MODE:    rb_data_o <= mode_word;
            RB_TIME_HI: rb_data_o <= vita_time_i[63:32];   // Seconds
            RB_TIME_LO: rb_data_o <= vita_time_i[31:0];    // Ticks
            RB_COMPAT:  rb_data_o <= COMPAT_NUM;
            RB_PPS_HI:  rb_data_o <= vita_time_pps_i[63:32];
            RB_PPS_LO:  rb_data_o <= vita_time_pps_i[31:0];
            default:    rb_data_o <= '0;
         endcase
      end
   end

endmodule

`default_nettype wire

// File: design/radio_ctrl_top.sv
/*
 * Radio core control plane on dsp_clk: host port, VITA timer,
 * control pin registers and status readback.
 */
`default_nettype none

module radio_ctrl_top
   import radio_ctrl_pkg::*;
#(
   parameter set_data_t TICKS_PER_SEC = DEFAULT_TICKS_PER_SEC
) (
   input  wire        dsp_clk,
   input  wire        por_rst,
   input  wire        host_req_i,
   input  wire        host_we_i,
   input  set_addr_t  host_addr_i,
   input  set_data_t  host_wdata_i,
   input  wire        pps_in_i,
   input  wire        clk_status_i,
   input  wire        sim_mode_i,
   input  wire [3:0]  clock_divider_i,
   output logic       host_ack_o,
   output set_data_t  host_rdata_o,
   output logic       clock_ready_o,
   output logic [1:0] clk_en_o,
   output logic [1:0] clk_sel_o,
   output logic       ser_enable_o,
   output logic       ser_prbsen_o,
   output logic       ser_loopen_o,
   output logic       ser_rx_en_o,
   output logic       adc_on_a_o,
   output logic       adc_oe_a_o,
   output logic       adc_on_b_o,
   output logic       adc_oe_b_o,
   output logic       phy_reset_n_o,
   output led_t       leds_o,
   output logic       pps_int_o
);

   logic         set_stb;
   set_addr_t    set_addr;
   set_data_t    set_data;
   rb_index_t    rb_index;
   set_data_t    rb_data;
   vita_time_t   vita_time, vita_time_pps;
   logic         pps_toggle;
   clock_ctrl_t  clock_ctrl;
   serdes_ctrl_t serdes_ctrl;
   adc_ctrl_t    adc_ctrl;

   ////////////////////////////////////////
   // Input side
   settings_host_port i_host_port (
      .dsp_clk, .por_rst, .host_req_i, .host_we_i, .host_addr_i, .host_wdata_i,
      .rb_data_i(rb_data), .host_ack_o, .host_rdata_o,
      .set_stb_o(set_stb), .set_addr_o(set_addr), .set_data_o(set_data),
      .rb_index_o(rb_index)
   );

   ////////////////////////////////////////
   // Processing
   vita_timer #(.TICKS_PER_SEC(TICKS_PER_SEC)) i_vita_timer (
      .dsp_clk, .por_rst, .set_stb_i(set_stb), .set_addr_i(set_addr),
      .set_data_i(set_data), .pps_in_i, .vita_time_o(vita_time),
      .vita_time_pps_o(vita_time_pps), .pps_int_o, .pps_toggle_o(pps_toggle)
   );

   control_outputs i_control_outputs (
      .dsp_clk, .por_rst, .set_stb_i(set_stb), .set_addr_i(set_addr),
      .set_data_i(set_data), .clk_status_i, .pps_toggle_i(pps_toggle),
      .clock_ctrl_o(clock_ctrl), .serdes_ctrl_o(serdes_ctrl), .adc_ctrl_o(adc_ctrl),
      .phy_reset_n_o, .leds_o
   );

   ////////////////////////////////////////
   // Output side
   status_readback i_status_readback (
      .dsp_clk, .por_rst, .rb_index_i(rb_index), .clock_ctrl_i(clock_ctrl),
      .serdes_ctrl_i(serdes_ctrl), .adc_ctrl_i(adc_ctrl), .sim_mode_i, .clock_divider_i,
      .vita_time_i(vita_time), .vita_time_pps_i(vita_time_pps), .rb_data_o(rb_data)
   );

   // Struct fields onto the pins
   assign {clock_ready_o, clk_en_o, clk_sel_o} = clock_ctrl;
   assign {ser_enable_o, ser_prbsen_o, ser_loopen_o, ser_rx_en_o} = serdes_ctrl;
   assign {adc_oe_a_o, adc_on_a_o, adc_oe_b_o, adc_on_b_o} = adc_ctrl;

endmodule

`default_nettype wire

// File: tb/radio_ctrl_tb_tasks.svh
/*
 * Host side of the four-phase req/ack transfer, one task per direction.
 */

task automatic wait_for_ack();
   int cycles;
   cycles = 0;
   while (!host_ack_o && cycles < ACK_TIMEOUT) begin
      @(negedge dsp_clk);
      cycles++;
   end
   if (!host_ack_o) begin
      $display("Timeout: host_ack_o did not rise within %0d cycles", ACK_TIMEOUT);
      timeout_count++;
   end
endtask

// Drop req, ack has to follow one cycle later
task automatic release_req();
   host_req_i = 1'b0;
   @(negedge dsp_clk);
   assert (!host_ack_o) else report_mismatch("host_ack_o", 0, host_ack_o);
endtask

task automatic host_write(input set_addr_t addr, input set_data_t data, input int hold);
   @(negedge dsp_clk);
   host_req_i   = 1'b1;
   host_we_i    = 1'b1;
   host_addr_i  = addr;
   host_wdata_i = data;
   wait_for_ack();
   repeat (hold) begin   // Host stalls with req still high
      @(negedge dsp_clk);
      assert (host_ack_o) else report_mismatch("host_ack_o", 1, host_ack_o);
   end
   release_req();
endtask

task automatic host_read(input rb_index_t idx);
   @(negedge dsp_clk);
   host_req_i  = 1'b1;
   host_we_i   = 1'b0;
   host_addr_i = {4'h0, idx};
   wait_for_ack();
   rd_word    = host_rdata_o;   // Held while ack is high
   rd_index   = idx;
   rd_pending = 1'b1;
   release_req();
endtask

// File: tb/radio_ctrl_tb.sv
/*
 * Radio control plane testbench: host writes and reads, LED mux and
 * VITA time latching checked against a shadow model.
 */
`default_nettype none

module radio_ctrl_tb
   import radio_ctrl_pkg::*;
();

   localparam int ACK_TIMEOUT = 20;
   localparam int PPS_TIMEOUT = 10;
   localparam int TICKS       = 1000;
   localparam int CLK_PERIOD  = 100;
   localparam int PPS_GAP     = 1500;

   logic       dsp_clk, por_rst;
   logic       host_req_i, host_we_i, pps_in_i, clk_status_i, sim_mode_i;
   set_addr_t  host_addr_i;
   set_data_t  host_wdata_i, host_rdata_o;
   logic [3:0] clock_divider_i;
   logic       host_ack_o, clock_ready_o, phy_reset_n_o, pps_int_o;
   logic [1:0] clk_en_o, clk_sel_o;
   logic       ser_enable_o, ser_prbsen_o, ser_loopen_o, ser_rx_en_o;
   logic       adc_on_a_o, adc_oe_a_o, adc_on_b_o, adc_oe_b_o;
   led_t       leds_o;

   // Shadow of the written settings and expected PPS state
   logic [4:0] sh_clock;
   logic [3:0] sh_serdes, sh_adc;
   logic       sh_phy, exp_toggle, rd_pending;
   led_t       sh_led_sw, sh_led_src;
   vita_time_t exp_pps;
   set_data_t  rd_word;
   rb_index_t  rd_index;
   int         exp_pulses, pps_pulses, serdes_changes;
   int         mismatch_count, timeout_count;
   integer     seed;
   time        pps_rise;
   event       check_ev;
   set_addr_t  pin_addrs [4]   = '{8'd0, 8'd1, 8'd2, 8'd4};
   set_addr_t  other_addrs [6] = '{8'd5, 8'd6, 8'd7, 8'd9, 8'd16, 8'd200};

   `include "radio_ctrl_tb_tasks.svh"

   radio_ctrl_top #(.TICKS_PER_SEC(TICKS)) i_radio_ctrl_top (
      .dsp_clk, .por_rst, .host_req_i, .host_we_i, .host_addr_i, .host_wdata_i,
      .pps_in_i, .clk_status_i, .sim_mode_i, .clock_divider_i,
      .host_ack_o, .host_rdata_o, .clock_ready_o, .clk_en_o, .clk_sel_o,
      .ser_enable_o, .ser_prbsen_o, .ser_loopen_o, .ser_rx_en_o,
      .adc_on_a_o, .adc_oe_a_o, .adc_on_b_o, .adc_oe_b_o,
      .phy_reset_n_o, .leds_o, .pps_int_o
   );

   initial begin
      dsp_clk = 1'b0;
      forever #(CLK_PERIOD / 2) dsp_clk = ~dsp_clk;
   end

   ////////////////////////////////////////
   // Reference model
   function automatic set_data_t ref_word(input rb_index_t idx);
      case (idx)
         RB_CTRL:   return {19'b0, sh_adc, sh_serdes, sh_clock};
         RB_MODE:   return {sim_mode_i, 27'b0, clock_divider_i};
         RB_COMPAT: return 32'd4;
         RB_PPS_HI: return exp_pps[63:32];
         RB_PPS_LO: return exp_pps[31:0];
         default:   return '0;
      endcase
   endfunction

   function automatic led_t ref_leds();
      led_t hw, leds;
      hw = {6'b0, exp_toggle, clk_status_i};
      for (int b = 0; b < 8; b++)
         leds[b] = sh_led_src[b] ? hw[b] : sh_led_sw[b];
      return leds;
   endfunction

   // Seconds and ticks after a number of counted cycles
   function automatic vita_time_t advance_time(input vita_time_t t0, input int cycles);
      longint unsigned total;
      total = t0[63:32];
      total = total * TICKS + t0[31:0] + cycles;
      return {32'(total / TICKS), 32'(total % TICKS)};
   endfunction

   task automatic report_mismatch(input string name, input logic [63:0] expected,
                                  input logic [63:0] actual);
      $display("Mismatch at %0t: %s expected 0x%0h, actual 0x%0h",
               $time, name, expected, actual);
      mismatch_count++;
   endtask

   ////////////////////////////////////////
   // Stimulus helpers
   task automatic write_setting(input set_addr_t addr, input set_data_t data, input int hold);
      case (addr)
         SR_MISC + SR_CLOCK_OFS:   sh_clock   = data[4:0];
         SR_MISC + SR_SERDES_OFS:  sh_serdes  = data[3:0];
         SR_MISC + SR_ADC_OFS:     sh_adc     = data[3:0];
         SR_MISC + SR_PHY_OFS:     sh_phy     = data[0];
         SR_MISC + SR_LED_SW_OFS:  sh_led_sw  = data[7:0];
         SR_MISC + SR_LED_SRC_OFS: sh_led_src = data[7:0];
         default: ;
      endcase
      host_write(addr, data, hold);
   endtask

   task automatic check_now();
      repeat (2) @(posedge dsp_clk);   // Let registered outputs settle
      @(negedge dsp_clk);
      -> check_ev;
      @(posedge dsp_clk);
   endtask

   // Called on a falling edge
   task automatic pulse_pps();
      int cycles;
      cycles     = 0;
      pps_in_i   = 1'b1;
      pps_rise   = $time;
      exp_toggle = ~exp_toggle;
      exp_pulses++;
      while (!pps_int_o && cycles < PPS_TIMEOUT) begin
         @(negedge dsp_clk);
         cycles++;
      end
      if (!pps_int_o) begin
         $display("Timeout: no PPS interrupt within %0d cycles of pps_in_i rising",
                  PPS_TIMEOUT);
         timeout_count++;
      end
      repeat (4) @(negedge dsp_clk);
      pps_in_i = 1'b0;
      repeat (4) @(negedge dsp_clk);
   endtask

   ////////////////////////////////////////
   // Monitors and comparing process
   always @(negedge dsp_clk) begin
      if (pps_int_o)
         pps_pulses++;
      if (i_radio_ctrl_top.i_control_outputs.i_sr_serdes.changed_o)
         serdes_changes++;
   end

   always begin
      @(check_ev);
      assert ({clock_ready_o, clk_en_o, clk_sel_o} == sh_clock)
         else report_mismatch("clock pins", sh_clock, {clock_ready_o, clk_en_o, clk_sel_o});
      assert ({ser_enable_o, ser_prbsen_o, ser_loopen_o, ser_rx_en_o} == sh_serdes)
         else report_mismatch("serdes pins", sh_serdes,
                              {ser_enable_o, ser_prbsen_o, ser_loopen_o, ser_rx_en_o});
      assert ({adc_oe_a_o, adc_on_a_o, adc_oe_b_o, adc_on_b_o} == sh_adc)
         else report_mismatch("adc pins", sh_adc,
                              {adc_oe_a_o, adc_on_a_o, adc_oe_b_o, adc_on_b_o});
      assert (phy_reset_n_o == !sh_phy)
         else report_mismatch("phy_reset_n_o", !sh_phy, phy_reset_n_o);
      assert (leds_o == ref_leds()) else report_mismatch("leds_o", ref_leds(), leds_o);
      assert (!host_ack_o) else report_mismatch("host_ack_o", 0, host_ack_o);
      assert (pps_pulses == exp_pulses)
         else report_mismatch("pps_int_o pulse count", exp_pulses, pps_pulses);
      if (rd_pending) begin
         assert (rd_word == ref_word(rd_index))
            else report_mismatch("host_rdata_o", ref_word(rd_index), rd_word);
         rd_pending = 1'b0;
      end
   end

   ////////////////////////////////////////
   // Test sequence
   initial begin
      set_data_t s, t;
      int        idx, changes_before;
      seed            = 32'hcb91_aae6;
      por_rst         = 1'b1;
      host_req_i      = 1'b0;
      host_we_i       = 1'b0;
      host_addr_i     = '0;
      host_wdata_i    = '0;
      pps_in_i        = 1'b0;
      clk_status_i    = 1'b0;
      sim_mode_i      = 1'b1;
      clock_divider_i = 4'ha;
      sh_clock        = '0;
      sh_serdes       = '0;
      sh_adc          = '0;
      sh_phy          = 1'b0;
      sh_led_sw       = '0;
      sh_led_src      = 8'b0000_0011;
      exp_toggle      = 1'b0;
      exp_pps         = '0;
      rd_pending      = 1'b0;
      repeat (3) @(posedge dsp_clk);
      @(negedge dsp_clk);
      por_rst = 1'b0;

      // Reset state and constant words
      check_now();
      host_read(RB_COMPAT);
      check_now();
      host_read(RB_MODE);
      check_now();

      // LED source at reset routes clk_status to bit 0
      @(negedge dsp_clk);
      clk_status_i = 1'b1;
      check_now();

      repeat (12) begin
         idx = $unsigned($random(seed)) % 4;
         write_setting(pin_addrs[idx], $random(seed), 0);
         check_now();
         host_read(RB_CTRL);
         check_now();
      end
      foreach (other_addrs[i])
         write_setting(other_addrs[i], $random(seed), 0);   // Nobody decodes these
      check_now();
      host_read(RB_CTRL);
      check_now();

      // LED mux with clk_status and PPS toggle as hardware sources
      repeat (6) begin
         write_setting(SR_MISC + SR_LED_SW_OFS, $random(seed), 0);
         write_setting(SR_MISC + SR_LED_SRC_OFS, $random(seed), 0);
         clk_status_i = 1'($random(seed));
         check_now();
      end
      write_setting(SR_MISC + SR_LED_SRC_OFS, 32'h03, 0);
      pulse_pps();
      check_now();
      @(negedge dsp_clk);
      clk_status_i = ~clk_status_i;
      check_now();

      // Load armed for the next PPS edge
      s = $random(seed) & 32'h0fff_ffff;
      t = $unsigned($random(seed)) % TICKS;
      write_setting(SR_TIME64 + TIME_SECS_OFS, s, 0);
      write_setting(SR_TIME64 + TIME_TICKS_OFS, t, 0);
      write_setting(SR_TIME64 + TIME_ARM_OFS, 32'h0, 0);
      pulse_pps();
      exp_pps = {s, t};
      host_read(RB_PPS_HI);
      check_now();
      host_read(RB_PPS_LO);
      check_now();

      // Free running count across second wraps
      while ($time < pps_rise + PPS_GAP * CLK_PERIOD)
         @(negedge dsp_clk);
      pulse_pps();
      exp_pps = advance_time({s, t}, PPS_GAP);
      host_read(RB_PPS_HI);
      check_now();
      host_read(RB_PPS_LO);
      check_now();

      // Stalled handshake with one register update only
      changes_before = serdes_changes;
      write_setting(SR_MISC + SR_SERDES_OFS, $random(seed), 5);
      assert (serdes_changes == changes_before + 1)
         else report_mismatch("serdes change count", changes_before + 1, serdes_changes);
      check_now();

      $display("Errors: %0d mismatches, %0d timeouts", mismatch_count, timeout_count);
      if (mismatch_count == 0 && timeout_count == 0) begin
         $display("Testbench passed");
      end else begin
         $display("Testbench failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: build.f
+incdir+tb
design/radio_ctrl_pkg.sv
design/setting_reg.sv
design/settings_host_port.sv
design/vita_timer.sv
design/control_outputs.sv
design/status_readback.sv
design/radio_ctrl_top.sv
tb/radio_ctrl_tb.sv
